// ==== src/coreRegPkg.sv ====
/* Core register datapath types */

package coreRegPkg;

   // Data word and register index widths
   typedef logic [15:0] word_t;
   typedef logic [3:0]  regAddr_t;

   // Source addressing mode, only the constant generator meaning is used
   typedef logic [1:0]  addrMode_t;

   // Two-operand ALU operations
   typedef enum logic [3:0] {
      MOV  = 4'd0,
      ADD  = 4'd1,
      ADDC = 4'd2,
      SUB  = 4'd3,
      SUBC = 4'd4,
      CMP  = 4'd5,
      BIT  = 4'd6,
      BIC  = 4'd7,
      BIS  = 4'd8,
      XOR  = 4'd9,
      AND  = 4'd10
   } aluOp_t;

   // Arithmetic flags out of the ALU
   typedef struct packed {
      logic carry;
      logic zero;
      logic negative;
      logic overflow;
   } aluFlags_t;

   // Registers with a fixed role
   localparam regAddr_t RegPc  = 4'd0;
   localparam regAddr_t RegSp  = 4'd1;
   localparam regAddr_t RegSr  = 4'd2;
   localparam regAddr_t RegCg2 = 4'd3;

   // Flag positions inside the status register
   localparam int SrCarryBit = 0;
   localparam int SrZeroBit  = 1;
   localparam int SrNegBit   = 2;
   localparam int SrOvfBit   = 8;

endpackage

// ==== src/regFile.sv ====
/* Sixteen-entry register file */

`timescale 1ns/100ps

module regFile #(
   parameter coreRegPkg::word_t RstVec = 16'hF800
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 wrEn,
   input  coreRegPkg::regAddr_t wrAddr,
   input  coreRegPkg::word_t    wrData,
   input  coreRegPkg::word_t    pcNext,
   input  coreRegPkg::word_t    srNext,
   input  coreRegPkg::regAddr_t srcAddr,
   input  coreRegPkg::regAddr_t dstAddr,
   output coreRegPkg::word_t    srcData,
   output coreRegPkg::word_t    dstData,
   output coreRegPkg::word_t    pc,
   output coreRegPkg::word_t    sp,
   output coreRegPkg::word_t    sr
);

   import coreRegPkg::*;

   // R0 PC, R1 SP, R2 SR, R3 constant source only
   word_t regs [16];

   logic  genWrite;

   // General port covers R1 and R4 to R15
   // R0 and R2 come from their own units, R3 swallows writes
   always_comb
   begin
      genWrite = wrEn;
      if (wrAddr == RegPc || wrAddr == RegSr || wrAddr == RegCg2)
      begin
         genWrite = 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < 16; i++)
         begin
            regs[i] <= '0;
         end
         regs[RegPc] <= RstVec;
      end
      else
      begin
         // PC and SR reload every cycle
         regs[RegPc] <= pcNext;
         regs[RegSr] <= srNext;
         if (genWrite)
         begin
            regs[wrAddr] <= wrData;
         end
      end
   end

   // Combinational operand reads
   assign srcData = regs[srcAddr];
   assign dstData = regs[dstAddr];

   // Special registers straight out
   assign pc = regs[RegPc];
   assign sp = regs[RegSp];
   assign sr = regs[RegSr];

endmodule

// ==== src/constGen.sv ====
/* Source operand constant generator */

`timescale 1ns/100ps

module constGen (
   input  coreRegPkg::regAddr_t  srcAddr,
   input  coreRegPkg::addrMode_t srcMode,
   input  coreRegPkg::word_t     srcData,
   output coreRegPkg::word_t     srcOperand
);

   import coreRegPkg::*;

   // Constant table keyed on mode and source register
   always_comb
   begin
      case ({srcMode, srcAddr})
         // R2 gives SR in mode 0, constants otherwise
         {2'd0, RegSr}:  srcOperand = srcData;
         {2'd1, RegSr}:  srcOperand = 16'h0000;
         {2'd2, RegSr}:  srcOperand = 16'h0004;
         {2'd3, RegSr}:  srcOperand = 16'h0008;

         // R3 is a pure constant source
         {2'd0, RegCg2}: srcOperand = 16'h0000;
         {2'd1, RegCg2}: srcOperand = 16'h0001;
         {2'd2, RegCg2}: srcOperand = 16'h0002;
         {2'd3, RegCg2}: srcOperand = 16'hFFFF;

         // Plain register, mode ignored
         default:        srcOperand = srcData;
      endcase
   end

endmodule

// ==== src/execUnit.sv ====
/* ALU and writeback select */

`timescale 1ns/100ps

module execUnit (
   input  logic               exec,
   input  logic               load,
   input  coreRegPkg::aluOp_t op,
   input  coreRegPkg::word_t  srcOperand,
   input  coreRegPkg::word_t  dstOperand,
   input  coreRegPkg::word_t  loadData,
   input  logic               carryIn,
   output coreRegPkg::word_t  result,
   output coreRegPkg::aluFlags_t flags,
   output logic               flagUpdate,
   output logic               wrEn,
   output coreRegPkg::word_t  wrData
);

   import coreRegPkg::*;

   word_t       addB;
   logic        addCin;
   logic [16:0] sum;
   logic        arith;
   logic        sumOvf;

   // Shared adder operand and carry in
   always_comb
   begin
      addB   = srcOperand;
      addCin = 1'b0;
      arith  = 1'b1;
      case (op)
         ADD:      addCin = 1'b0;
         ADDC:     addCin = carryIn;
         SUB, CMP:
         begin
            addB   = ~srcOperand;
            addCin = 1'b1;
         end
         SUBC:
         begin
            addB   = ~srcOperand;
            addCin = carryIn;
         end
         default:  arith = 1'b0;
      endcase
   end

   assign sum = {1'b0, dstOperand} + {1'b0, addB} + 17'(addCin);

   // Same-sign inputs, different-sign output
   assign sumOvf = (dstOperand[15] == addB[15]) && (sum[15] != dstOperand[15]);

   always_comb
   begin
      case (op)
         MOV:      result = srcOperand;
         AND, BIT: result = dstOperand & srcOperand;
         XOR:      result = dstOperand ^ srcOperand;
         BIC:      result = dstOperand & ~srcOperand;
         BIS:      result = dstOperand | srcOperand;
         default:  result = sum[15:0];
      endcase
   end

   always_comb
   begin
      flags.zero     = (result == '0);
      flags.negative = result[15];
      // Logic ops report C as not Z and clear V
      flags.carry    = arith ? sum[16] : ~flags.zero;
      flags.overflow = arith ? sumOvf : 1'b0;
   end

   // Load wins over exec when both strobe
   assign flagUpdate = exec && !load && !(op inside {MOV, BIC, BIS});
   assign wrEn       = load || (exec && !(op inside {CMP, BIT}));
   assign wrData     = load ? loadData : result;

endmodule

// ==== src/pcUnit.sv ====
/* Program counter next-state logic */

`timescale 1ns/100ps

module pcUnit #(
   parameter coreRegPkg::word_t RstVec = 16'hF800
) (
   input  logic                 step,
   input  logic                 wrEn,
   input  coreRegPkg::regAddr_t dstAddr,
   input  coreRegPkg::word_t    wrData,
   input  coreRegPkg::word_t    pc,
   output coreRegPkg::word_t    pcNext
);

   import coreRegPkg::*;

   // Highest address that is not a valid code location
   localparam word_t GuardLimit = 16'h01FF;

   logic  pcWrite;
   word_t pcInc;
   word_t pcWrTarget;

   assign pcWrite = wrEn && (dstAddr == RegPc);
   assign pcInc   = pc + 16'd2;

   // Low addresses bounce to the reset vector
   assign pcWrTarget = (wrData > GuardLimit) ? wrData : RstVec;

   always_comb
   begin
      if (pcWrite)
      begin
         pcNext = pcWrTarget;
      end
      else if (step)
      begin
         pcNext = pcInc;
      end
      else
      begin
         // Idle cycle
         pcNext = pc;
      end
   end

endmodule

// ==== src/statusUnit.sv ====
/* Status register next-state logic */

`timescale 1ns/100ps

module statusUnit (
   input  logic                  wrEn,
   input  coreRegPkg::regAddr_t  dstAddr,
   input  coreRegPkg::word_t     wrData,
   input  coreRegPkg::word_t     sr,
   input  coreRegPkg::aluFlags_t flags,
   input  logic                  flagUpdate,
   output coreRegPkg::word_t     srNext
);

   import coreRegPkg::*;

   logic  srWrite;
   word_t srMerged;

   assign srWrite = wrEn && (dstAddr == RegSr);

   // Drop the four flags into place, keep the rest
   always_comb
   begin
      srMerged             = sr;
      srMerged[SrCarryBit] = flags.carry;
      srMerged[SrZeroBit]  = flags.zero;
      srMerged[SrNegBit]   = flags.negative;
      srMerged[SrOvfBit]   = flags.overflow;
   end

   // Direct write beats flag update
   always_comb
   begin
      if (srWrite)
      begin
         srNext = wrData;
      end
      else if (flagUpdate)
      begin
         srNext = srMerged;
      end
      else
      begin
         srNext = sr;
      end
   end

endmodule

// ==== src/regDatapath.sv ====
/* Register datapath top level */

`timescale 1ns/100ps

module regDatapath #(
   parameter coreRegPkg::word_t RstVec = 16'hF800
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  exec,
   input  logic                  load,
   input  coreRegPkg::aluOp_t    op,
   input  coreRegPkg::regAddr_t  srcReg,
   input  coreRegPkg::regAddr_t  dstReg,
   input  coreRegPkg::addrMode_t srcMode,
   input  coreRegPkg::word_t     loadData,
   output coreRegPkg::word_t     pc,
   output coreRegPkg::word_t     sp,
   output coreRegPkg::word_t     sr,
   output coreRegPkg::word_t     result
);

   import coreRegPkg::*;

   word_t     srcData;
   word_t     dstData;
   word_t     srcOperand;
   word_t     wrData;
   word_t     pcNext;
   word_t     srNext;
   aluFlags_t flags;
   logic      flagUpdate;
   logic      wrEn;

   regFile #(.RstVec(RstVec)) regs (
      .clk     (clk),
      .rst     (rst),
      .wrEn    (wrEn),
      .wrAddr  (dstReg),
      .wrData  (wrData),
      .pcNext  (pcNext),
      .srNext  (srNext),
      .srcAddr (srcReg),
      .dstAddr (dstReg),
      .srcData (srcData),
      .dstData (dstData),
      .pc      (pc),
      .sp      (sp),
      .sr      (sr)
   );

   constGen cg (
      .srcAddr    (srcReg),
      .srcMode    (srcMode),
      .srcData    (srcData),
      .srcOperand (srcOperand)
   );

   execUnit alu (
      .exec       (exec),
      .load       (load),
      .op         (op),
      .srcOperand (srcOperand),
      .dstOperand (dstData),
      .loadData   (loadData),
      .carryIn    (sr[SrCarryBit]),
      .result     (result),
      .flags      (flags),
      .flagUpdate (flagUpdate),
      .wrEn       (wrEn),
      .wrData     (wrData)
   );

   // Either strobe counts as one accepted step
   pcUnit #(.RstVec(RstVec)) pcu (
      .step    (exec | load),
      .wrEn    (wrEn),
      .dstAddr (dstReg),
      .wrData  (wrData),
      .pc      (pc),
      .pcNext  (pcNext)
   );

   statusUnit stu (
      .wrEn       (wrEn),
      .dstAddr    (dstReg),
      .wrData     (wrData),
      .sr         (sr),
      .flags      (flags),
      .flagUpdate (flagUpdate),
      .srNext     (srNext)
   );

endmodule

// ==== sim/regDatapathModel.svh ====
/* Register datapath reference model */

`ifndef REG_DATAPATH_MODEL_SVH
`define REG_DATAPATH_MODEL_SVH

// Expected register contents, R3 is never written
word_t mRegs [16];

// Source operand after the R2 and R3 constant table
function automatic word_t modelOperand(regAddr_t a, addrMode_t m);
   word_t v;
   v = mRegs[a];
   if (a == RegCg2)
   begin
      v = (m == 2'd3) ? 16'hFFFF : word_t'(m);
   end
   else if (a == RegSr && m != 2'd0)
   begin
      v = (m == 2'd1) ? 16'h0000 : ((m == 2'd2) ? 16'h0004 : 16'h0008);
   end
   return v;
endfunction

// Exact integer sums give carry and signed overflow
function automatic word_t modelAdd(word_t a, word_t b, logic cin, output logic c,
                                   output logic v);
   int unsigned u;
   int          s;
   u = int'(a) + int'(b) + int'(cin);
   s = int'($signed(a)) + int'($signed(b)) + int'(cin);
   c = (u > 32'hFFFF);
   v = (s > 32767) || (s < -32768);
   return word_t'(u);
endfunction

function automatic word_t modelAlu(aluOp_t o, word_t s, word_t d, logic cin,
                                   output aluFlags_t f);
   word_t r;
   logic  c;
   logic  v;
   c = 1'b0;
   v = 1'b0;
   case (o)
      ADD:      r = modelAdd(d, s, 1'b0, c, v);
      ADDC:     r = modelAdd(d, s, cin, c, v);
      SUB, CMP: r = modelAdd(d, ~s, 1'b1, c, v);
      SUBC:     r = modelAdd(d, ~s, cin, c, v);
      AND, BIT: r = d & s;
      XOR:      r = d ^ s;
      BIC:      r = d & ~s;
      BIS:      r = d | s;
      default:  r = s;
   endcase
   // Logic results carry when nonzero
   if (!(o inside {ADD, ADDC, SUB, SUBC, CMP}))
   begin
      c = (r != 16'h0000);
   end
   f = '{carry: c, zero: (r == 16'h0000), negative: r[15], overflow: v};
   return r;
endfunction

task automatic modelReset();
   foreach (mRegs[i])
   begin
      mRegs[i] = 16'h0000;
   end
   mRegs[RegPc] = RstVec;
endtask

// State after the clock edge that takes these inputs
task automatic modelStep(logic ex, logic ld, aluOp_t o, regAddr_t s, regAddr_t d,
                         addrMode_t m, word_t data);
   word_t     res;
   aluFlags_t f;
   logic      wr;
   logic      upd;
   word_t     wd;
   res = modelAlu(o, modelOperand(s, m), mRegs[d], mRegs[RegSr][SrCarryBit], f);
   wr  = ld || (ex && o != CMP && o != BIT);
   upd = ex && !ld && o != MOV && o != BIC && o != BIS;
   wd  = ld ? data : res;
   if (wr && d == RegPc)
   begin
      mRegs[RegPc] = (wd > 16'h01FF) ? wd : RstVec;
   end
   else if (ex || ld)
   begin
      mRegs[RegPc] = mRegs[RegPc] + 16'd2;
   end
   if (wr && d == RegSr)
   begin
      mRegs[RegSr] = wd;
   end
   else if (upd)
   begin
      mRegs[RegSr][SrCarryBit] = f.carry;
      mRegs[RegSr][SrZeroBit]  = f.zero;
      mRegs[RegSr][SrNegBit]   = f.negative;
      mRegs[RegSr][SrOvfBit]   = f.overflow;
   end
   if (wr && d != RegPc && d != RegSr && d != RegCg2)
   begin
      mRegs[d] = wd;
   end
endtask

`endif

// ==== sim/regDatapathTb.sv ====
/* Register datapath testbench */

`timescale 1ns/100ps

module regDatapathTb;

   import coreRegPkg::*;

   localparam word_t RstVec         = 16'hF800;
   localparam int    ResetCycles    = 5;
   localparam int    DirectedCycles = 30;
   localparam int    RandCycles     = 2000;
   localparam int    CycleLimit     = ResetCycles + DirectedCycles + RandCycles + 65;

   logic      clk;
   logic      rst;
   logic      exec;
   logic      load;
   aluOp_t    op;
   regAddr_t  srcReg;
   regAddr_t  dstReg;
   addrMode_t srcMode;
   word_t     loadData;
   word_t     pc;
   word_t     sp;
   word_t     sr;
   word_t     result;
   int        cycleCount = 0;
   string     testName;
   aluFlags_t expSrFlags;

   `include "regDatapathModel.svh"

   regDatapath #(.RstVec(RstVec)) uut (.*);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #50 clk = ~clk;
      end
   end

   task automatic failRun();
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= CycleLimit)
      begin
         $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
         failRun();
      end
   end

   task automatic checkWord(string name, word_t expected, word_t actual);
      if (actual !== expected)
      begin
         $display("ERROR %s: expected %h, actual %h", name, expected, actual);
         failRun();
      end
   endtask

   task automatic checkFlags(string name, aluFlags_t expected, aluFlags_t actual);
      if (actual !== expected)
      begin
         $display("ERROR %s: expected %b, actual %b", name, expected, actual);
         failRun();
      end
   endtask

   function automatic aluFlags_t srFlags(word_t s);
      return '{carry: s[SrCarryBit], zero: s[SrZeroBit], negative: s[SrNegBit],
               overflow: s[SrOvfBit]};
   endfunction

   // Drive after the edge, check just before the next one
   task automatic runCycle(logic ex, logic ld, aluOp_t o, regAddr_t s, regAddr_t d,
                           addrMode_t m, word_t data);
      word_t     expResult;
      aluFlags_t expFlags;
      @(posedge clk);
      #10;
      exec     = ex;
      load     = ld;
      op       = o;
      srcReg   = s;
      dstReg   = d;
      srcMode  = m;
      loadData = data;
      #70;
      expResult = modelAlu(o, modelOperand(s, m), mRegs[d], mRegs[RegSr][SrCarryBit],
                           expFlags);
      checkWord({testName, " result"}, expResult, result);
      checkWord({testName, " pc"}, mRegs[RegPc], pc);
      checkWord({testName, " sp"}, mRegs[RegSp], sp);
      checkFlags({testName, " sr flags"}, expSrFlags, srFlags(sr));
      checkWord({testName, " sr"}, mRegs[RegSr], sr);
      // Flags the SR must show after this edge
      if ((ld || (ex && o != CMP && o != BIT)) && d == RegSr)
      begin
         expSrFlags = srFlags(ld ? data : expResult);
      end
      else if (ex && !ld && !(o inside {MOV, BIC, BIS}))
      begin
         expSrFlags = expFlags;
      end
      modelStep(ex, ld, o, s, d, m, data);
   endtask

   // About 25% load, 60% exec, 15% idle
   task automatic randomCycle();
      int unsigned pick;
      regAddr_t    d;
      word_t       data;
      pick = $urandom_range(99);
      d    = regAddr_t'($urandom);
      data = word_t'($urandom);
      if (pick < 25 && $urandom_range(7) == 0)
      begin
         d = RegPc;
      end
      // Low words hit the PC guard
      if ($urandom_range(3) == 0)
      begin
         data = word_t'($urandom_range(16'h01FF));
      end
      runCycle(pick >= 25 && pick < 85, pick < 25, aluOp_t'(4'($urandom_range(10))),
               regAddr_t'($urandom), d, addrMode_t'($urandom), data);
   endtask

   initial
   begin
      rst      = 1'b1;
      exec     = 1'b0;
      load     = 1'b0;
      op       = MOV;
      srcReg   = '0;
      dstReg   = '0;
      srcMode  = '0;
      loadData = '0;
      testName = "reset";
      void'($urandom(32'h233e_a368));
      modelReset();
      expSrFlags = '0;
      repeat (ResetCycles) @(posedge clk);
      #10;
      rst = 1'b0;
      checkWord("reset pc", RstVec, pc);
      checkWord("reset sp", 16'h0000, sp);
      checkWord("reset sr", 16'h0000, sr);
      for (int r = 4; r < 16; r++)
      begin
         runCycle(1'b1, 1'b0, MOV, regAddr_t'(r), regAddr_t'(r), 2'd0, '0);
      end

      testName = "const gen";
      runCycle(1'b0, 1'b1, MOV, '0, RegCg2, 2'd0, 16'hBEEF);
      for (int m = 0; m < 4; m++)
      begin
         runCycle(1'b1, 1'b0, MOV, RegSr, 4'd4, addrMode_t'(m), '0);
         runCycle(1'b1, 1'b0, MOV, RegCg2, 4'd5, addrMode_t'(m), '0);
      end

      testName = "pc guard";
      runCycle(1'b0, 1'b1, MOV, '0, RegPc, 2'd0, 16'h0200);
      runCycle(1'b0, 1'b1, MOV, '0, RegPc, 2'd0, 16'h01FF);
      runCycle(1'b0, 1'b0, MOV, '0, '0, 2'd0, '0);
      runCycle(1'b0, 1'b0, MOV, '0, '0, 2'd0, '0);
      runCycle(1'b1, 1'b0, MOV, RegCg2, RegPc, 2'd3, '0);

      testName = "sr write";
      runCycle(1'b0, 1'b1, MOV, '0, RegSr, 2'd0, 16'h1234);
      runCycle(1'b1, 1'b0, ADD, 4'd5, RegSr, 2'd0, '0);

      testName = "random";
      repeat (RandCycles) randomCycle();

      testName = "final";
      runCycle(1'b0, 1'b0, MOV, '0, '0, 2'd0, '0);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+sim
src/coreRegPkg.sv
src/regFile.sv
src/constGen.sv
src/execUnit.sv
src/pcUnit.sv
src/statusUnit.sv
src/regDatapath.sv
sim/regDatapathTb.sv

// ==== Makefile ====
# Verilator run of the register datapath testbench
TOP = regDatapathTb

sim:
	verilator --binary --timing --top-module $(TOP) -f all.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
